// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert --timescale 1ns/1ns
TOP      = simf_alu_tb
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A crashed or stopped simulation also counts as a failure
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Checks failed" >> $(LOG)
	cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rtl/simf_alu.sv ====
`timescale 1ns/1ns

module simf_alu
(
   input  logic                clk,
   input  logic                rst_n_i,
   input  simf_alu_pkg::word_t alu_source1_data_i,
   input  simf_alu_pkg::word_t alu_source2_data_i,
   input  simf_alu_pkg::ctrl_t alu_control_i,
   input  logic                alu_source_exec_value_i,
   input  logic                alu_source_vcc_value_i,
   input  logic                alu_start_i,
   output simf_alu_pkg::word_t alu_vgpr_dest_data_o,
   output logic                alu_dest_vcc_value_o,
   output logic                alu_done_o
);

   import simf_alu_pkg::*;

   alu_op_e   op_kind;
   cmp_cond_t cmp_cond;
   logic      mul_load;
   logic      mul_step;
   logic      cnt_load;
   logic      cnt_en;
   logic      cnt_last;
   logic      wb_load;
   logic      cmp_result;
   word_t     max_result;
   word_t     product;

   simf_alu_decoder u_decoder
   (
      .exec_i     (alu_source_exec_value_i),
      .ctrl_i     (alu_control_i),
      .op_kind_o  (op_kind),
      .cmp_cond_o (cmp_cond)
   );

   simf_alu_cmp_unit u_cmp_unit
   (
      .src_a_i      (alu_source1_data_i),
      .src_b_i      (alu_source2_data_i),
      .cond_i       (cmp_cond),
      .cmp_result_o (cmp_result),
      .max_result_o (max_result)
   );

   simf_alu_step_counter u_step_counter
   (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .load_i  (cnt_load),
      .en_i    (cnt_en),
      .last_o  (cnt_last)
   );

   simf_alu_ctrl_fsm u_ctrl_fsm
   (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .start_i    (alu_start_i),
      .op_kind_i  (op_kind),
      .cnt_last_i (cnt_last),
      .mul_load_o (mul_load),
      .mul_step_o (mul_step),
      .cnt_load_o (cnt_load),
      .cnt_en_o   (cnt_en),
      .wb_load_o  (wb_load)
   );

   simf_alu_mul_datapath u_mul_datapath
   (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .load_i    (mul_load),
      .step_i    (mul_step),
      .src_a_i   (alu_source1_data_i),
      .src_b_i   (alu_source2_data_i),
      .product_o (product)
   );

   simf_alu_writeback u_writeback
   (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .load_i    (wb_load),
      .op_kind_i (op_kind),
      .product_i (product),
      .max_i     (max_result),
      .cmp_i     (cmp_result),
      .vcc_i     (alu_source_vcc_value_i),
      .vgpr_o    (alu_vgpr_dest_data_o),
      .vcc_o     (alu_dest_vcc_value_o),
      .done_o    (alu_done_o)
   );

endmodule

// ==== rtl/simf_alu_cmp_unit.sv ====
`timescale 1ns/1ns

module simf_alu_cmp_unit
(
   input  simf_alu_pkg::word_t     src_a_i,
   input  simf_alu_pkg::word_t     src_b_i,
   input  simf_alu_pkg::cmp_cond_t cond_i,
   output logic                    cmp_result_o,
   output simf_alu_pkg::word_t     max_result_o
);

   logic a_lt_b;
   logic a_eq_b;
   logic a_gt_b;

   // Raw bit patterns compared as unsigned
   assign a_lt_b = (src_a_i < src_b_i);
   assign a_eq_b = (src_a_i == src_b_i);
   assign a_gt_b = (src_a_i > src_b_i);

   always_comb
   begin
      case (cond_i)
         4'h0:    cmp_result_o = 1'b0;                 // F
         4'h1:    cmp_result_o = a_lt_b;               // LT
         4'h2:    cmp_result_o = a_eq_b;               // EQ
         4'h3:    cmp_result_o = a_lt_b | a_eq_b;      // LE
         4'h4:    cmp_result_o = a_gt_b;               // GT
         4'h5:    cmp_result_o = ~a_eq_b;              // LG
         4'h6:    cmp_result_o = a_gt_b | a_eq_b;      // GE
         4'h9:    cmp_result_o = ~(a_gt_b | a_eq_b);   // NGE
         4'hA:    cmp_result_o = a_eq_b;               // NLG
         4'hB:    cmp_result_o = ~a_gt_b;              // NGT
         4'hC:    cmp_result_o = ~(a_lt_b | a_eq_b);   // NLE
         4'hD:    cmp_result_o = ~a_eq_b;              // NEQ
         4'hE:    cmp_result_o = ~a_lt_b;              // NLT
         4'hF:    cmp_result_o = 1'b1;                 // TRU
         default: cmp_result_o = 1'b0;                 // Codes 7 and 8
      endcase
   end

   // Ties select source A
   assign max_result_o = (a_gt_b | a_eq_b) ? src_a_i : src_b_i;

endmodule

// ==== rtl/simf_alu_ctrl_fsm.sv ====
`timescale 1ns/1ns

module simf_alu_ctrl_fsm
(
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  start_i,
   input  simf_alu_pkg::alu_op_e op_kind_i,
   input  logic                  cnt_last_i,
   output logic                  mul_load_o,
   output logic                  mul_step_o,
   output logic                  cnt_load_o,
   output logic                  cnt_en_o,
   output logic                  wb_load_o
);

   import simf_alu_pkg::*;

   alu_state_e state;
   alu_state_e state_nxt;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         state <= ST_IDLE;
      else
         state <= state_nxt;
   end

   always_comb
   begin
      state_nxt  = state;
      mul_load_o = 1'b0;
      mul_step_o = 1'b0;
      cnt_load_o = 1'b0;
      cnt_en_o   = 1'b0;
      wb_load_o  = 1'b0;
      case (state)
         ST_IDLE:
         begin
            if (start_i)
            begin
               if (op_kind_i == OP_MUL)
               begin
                  mul_load_o = 1'b1;       // Capture operands
                  cnt_load_o = 1'b1;
                  state_nxt  = ST_MUL_RUN;
               end
               else
                  wb_load_o = 1'b1;        // Single-cycle classes
            end
         end
         ST_MUL_RUN:
         begin
            mul_step_o = 1'b1;
            cnt_en_o   = 1'b1;
            if (cnt_last_i)
               state_nxt = ST_MUL_NORM;
         end
         ST_MUL_NORM:
         begin
            wb_load_o = 1'b1;              // Product is settled
            state_nxt = ST_IDLE;
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

endmodule

// ==== rtl/simf_alu_decoder.sv ====
`timescale 1ns/1ns

module simf_alu_decoder
(
   input  logic                    exec_i,
   input  simf_alu_pkg::ctrl_t     ctrl_i,
   output simf_alu_pkg::alu_op_e   op_kind_o,
   output simf_alu_pkg::cmp_cond_t cmp_cond_o
);

   import simf_alu_pkg::*;

   fmt_t    fmt;
   opcode_t opcode;
   logic    cmp_code;

   assign fmt        = ctrl_i[31:24];
   assign opcode     = ctrl_i[11:0];
   assign cmp_cond_o = opcode[3:0];

   // Codes 7 and 8 of the compare space are undefined
   assign cmp_code = (opcode[11:4] == 8'h00) && (opcode[3:0] != 4'h7) &&
                     (opcode[3:0] != 4'h8);

   always_comb
   begin
      op_kind_o = OP_PASS;
      if (exec_i)
      begin
         case (fmt)
            FMT_VOP1:  op_kind_o = OP_PASS;    // No VOP1 op in this slice
            FMT_VOP2:
            begin
               if (opcode == OPC_MUL_VOP2)
                  op_kind_o = OP_MUL;
               else if (opcode == OPC_MAX_VOP2)
                  op_kind_o = OP_MAX;
            end
            FMT_VOPC:
            begin
               if (cmp_code)
                  op_kind_o = OP_CMP;
            end
            FMT_VOP3A:
            begin
               if (opcode == OPC_MUL_VOP3)
                  op_kind_o = OP_MUL;
               else if (cmp_code)
                  op_kind_o = OP_CMP;
            end
            default:   op_kind_o = OP_PASS;
         endcase
      end
   end

endmodule

// ==== rtl/simf_alu_mul_datapath.sv ====
`timescale 1ns/1ns

module simf_alu_mul_datapath
(
   input  logic                clk,
   input  logic                rst_n_i,
   input  logic                load_i,
   input  logic                step_i,
   input  simf_alu_pkg::word_t src_a_i,
   input  simf_alu_pkg::word_t src_b_i,
   output simf_alu_pkg::word_t product_o
);

   import simf_alu_pkg::*;

   logic        sign_q;
   logic        zero_q;
   exp_t        exp_sum;
   mant_t       mplier;
   mant_t       mcand;
   prod_t       acc;
   exp_t        exp_norm;
   logic [22:0] frac;

   // Either operand has a zero exponent field
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         zero_q <= 1'b1;
      else if (load_i)
         zero_q <= (src_a_i[30:23] == 8'h00) || (src_b_i[30:23] == 8'h00);
   end

   always_ff @(posedge clk)
   begin
      if (load_i)
      begin
         sign_q  <= src_a_i[31] ^ src_b_i[31];
         exp_sum <= exp_t'({2'b00, src_a_i[30:23]}) +
                    exp_t'({2'b00, src_b_i[30:23]}) - EXP_BIAS;
         mplier  <= {1'b1, src_a_i[22:0]};
         mcand   <= {1'b1, src_b_i[22:0]};
         acc     <= '0;
      end
      else if (step_i)
      begin
         // Multiplier consumed MSB first
         acc    <= (acc << 1) + (mplier[23] ? prod_t'(mcand) : prod_t'(0));
         mplier <= mplier << 1;
      end
   end

   // Product lies in [1, 4) and is truncated
   assign exp_norm = exp_sum + exp_t'({9'd0, acc[47]});
   assign frac     = acc[47] ? acc[46:24] : acc[45:23];

   always_comb
   begin
      if (zero_q || (exp_norm <= 0))
         product_o = {sign_q, 31'd0};                      // Signed zero
      else if (exp_norm >= EXP_MAX)
         product_o = {sign_q, EXP_MAX[7:0], 23'd0};        // Signed infinity
      else
         product_o = {sign_q, exp_norm[7:0], frac};
   end

endmodule

// ==== rtl/simf_alu_pkg.sv ====
package simf_alu_pkg;

   // Data and control words
   typedef logic [31:0] word_t;
   typedef logic [31:0] ctrl_t;      // Format in [31:24], opcode in [11:0]
   typedef logic [7:0]  fmt_t;
   typedef logic [11:0] opcode_t;
   typedef logic [3:0]  cmp_cond_t;  // Low nibble of a compare opcode

   // Multiplier working types
   typedef logic [23:0]        mant_t;      // Mantissa with hidden bit
   typedef logic [47:0]        prod_t;
   typedef logic signed [9:0]  exp_t;       // Headroom for under and overflow
   typedef logic [4:0]         step_cnt_t;

   typedef enum logic [1:0]
   {
      OP_PASS,                       // Exec off or unknown opcode
      OP_MUL,
      OP_MAX,
      OP_CMP
   } alu_op_e;

   typedef enum logic [1:0]
   {
      ST_IDLE,
      ST_MUL_RUN,
      ST_MUL_NORM
   } alu_state_e;

   // Encoding formats
   localparam fmt_t FMT_VOP1  = 8'h01;
   localparam fmt_t FMT_VOP2  = 8'h02;
   localparam fmt_t FMT_VOPC  = 8'h04;
   localparam fmt_t FMT_VOP3A = 8'h08;

   // Compares use 000..00F in VOPC and VOP3A
   localparam opcode_t OPC_MUL_VOP2 = 12'h008;
   localparam opcode_t OPC_MUL_VOP3 = 12'h108;
   localparam opcode_t OPC_MAX_VOP2 = 12'h010;

   // Multiplier constants
   localparam step_cnt_t MUL_STEPS = 5'd24;
   localparam exp_t      EXP_BIAS  = 10'sd127;
   localparam exp_t      EXP_MAX   = 10'sd255;

endpackage

// ==== rtl/simf_alu_step_counter.sv ====
`timescale 1ns/1ns

module simf_alu_step_counter
(
   input  logic clk,
   input  logic rst_n_i,
   input  logic load_i,
   input  logic en_i,
   output logic last_o
);

   import simf_alu_pkg::*;

   step_cnt_t count;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         count <= '0;
      else if (load_i)
         count <= MUL_STEPS;
      else if (en_i && (count != '0))
         count <= count - 1'b1;     // One step per enabled cycle
   end

   assign last_o = (count == 5'd1);  // Final shift-add step

endmodule

// ==== rtl/simf_alu_writeback.sv ====
`timescale 1ns/1ns

module simf_alu_writeback
(
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  load_i,
   input  simf_alu_pkg::alu_op_e op_kind_i,
   input  simf_alu_pkg::word_t   product_i,
   input  simf_alu_pkg::word_t   max_i,
   input  logic                  cmp_i,
   input  logic                  vcc_i,
   output simf_alu_pkg::word_t   vgpr_o,
   output logic                  vcc_o,
   output logic                  done_o
);

   import simf_alu_pkg::*;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         vgpr_o <= '0;
         vcc_o  <= 1'b0;
         done_o <= 1'b0;
      end
      else
      begin
         done_o <= load_i;                 // One-cycle pulse
         if (load_i)
         begin
            case (op_kind_i)
               OP_MUL:
               begin
                  vgpr_o <= product_i;
                  vcc_o  <= vcc_i;
               end
               OP_MAX:
               begin
                  vgpr_o <= max_i;
                  vcc_o  <= vcc_i;
               end
               OP_CMP:  vcc_o <= cmp_i;    // VGPR left unchanged
               default: vcc_o <= vcc_i;
            endcase
         end
      end
   end

endmodule

// ==== sim.f ====
rtl/simf_alu_pkg.sv
rtl/simf_alu_decoder.sv
rtl/simf_alu_cmp_unit.sv
rtl/simf_alu_step_counter.sv
rtl/simf_alu_ctrl_fsm.sv
rtl/simf_alu_mul_datapath.sv
rtl/simf_alu_writeback.sv
rtl/simf_alu.sv
testbench/simf_alu_sva.sv
testbench/simf_alu_tb.sv

// ==== testbench/simf_alu_sva.sv ====
`timescale 1ns/1ns

module simf_alu_sva
(
   input logic clk,
   input logic rst_n_i,
   input logic start_i,
   input logic done_i
);

   logic busy;                             // Accepted start awaits its done

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         busy <= 1'b0;
      else if (done_i)
         busy <= start_i;                  // New start right after done
      else if (start_i)
         busy <= 1'b1;
   end

   done_pulse_a: assert property (@(posedge clk) disable iff (!rst_n_i) done_i |=> !done_i)
      else $error("alu_done_o stayed high for more than one cycle");

   done_after_start_a: assert property (@(posedge clk) disable iff (!rst_n_i) done_i |-> busy)
      else $error("alu_done_o rose without an earlier start");

   done_in_reset_a: assert property (@(posedge clk) !rst_n_i |-> !done_i)
      else $error("alu_done_o high during reset");

endmodule

bind simf_alu simf_alu_sva u_sva
(
   .clk     (clk),
   .rst_n_i (rst_n_i),
   .start_i (alu_start_i),
   .done_i  (alu_done_o)
);

// ==== testbench/simf_alu_tb.sv ====
`timescale 1ns/1ns

module simf_alu_tb;

   import simf_alu_pkg::*;

   localparam int DONE_TIMEOUT = 40;       // Cycles allowed per instruction
   localparam int RANDOM_CMPS  = 32;

   logic  clk;
   logic  rst_n;
   word_t src1;
   word_t src2;
   ctrl_t ctrl;
   logic  exec_v;
   logic  vcc_in;
   logic  start;
   word_t vgpr_out;
   logic  vcc_out;
   logic  done;

   integer seed;
   int     test_count;
   int     failed_tests;
   int     check_total;
   int     error_count;
   logic   timed_out;
   logic   file_error;
   word_t  vgpr_model;                     // Last VGPR value written

   simf_alu DUT
   (
      .clk                     (clk),
      .rst_n_i                 (rst_n),
      .alu_source1_data_i      (src1),
      .alu_source2_data_i      (src2),
      .alu_control_i           (ctrl),
      .alu_source_exec_value_i (exec_v),
      .alu_source_vcc_value_i  (vcc_in),
      .alu_start_i             (start),
      .alu_vgpr_dest_data_o    (vgpr_out),
      .alu_dest_vcc_value_o    (vcc_out),
      .alu_done_o              (done)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic check_word(input string name, input word_t exp_v, input word_t act_v);
      check_total++;
      if (act_v !== exp_v)
      begin
         error_count++;
         $display("ERROR at %0t ns: %s expected %08h, got %08h", $time, name, exp_v, act_v);
      end
   endtask

   task automatic check_bit(input string name, input logic exp_v, input logic act_v);
      check_total++;
      if (act_v !== exp_v)
      begin
         error_count++;
         $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp_v, act_v);
      end
   endtask

   task automatic check_count(input string name, input int exp_v, input int act_v);
      check_total++;
      if (act_v != exp_v)
      begin
         error_count++;
         $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, exp_v, act_v);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      test_count++;
      if (timed_out || (error_count != errs_before))
      begin
         failed_tests++;
         $display("[FAIL] %s", name);
      end
      else
         $display("[PASS] %s", name);
   endtask

   // Multiplies finish after edge 25, all other classes after edge 0
   function automatic int done_edge(input ctrl_t c, input logic ex);
      fmt_t    f;
      opcode_t o;
      f = c[31:24];
      o = c[11:0];
      if (ex && (((f == FMT_VOP2) && (o == OPC_MUL_VOP2)) ||
                 ((f == FMT_VOP3A) && (o == OPC_MUL_VOP3))))
         return int'(MUL_STEPS) + 1;
      return 0;
   endfunction

   function automatic logic compare_expected(input cmp_cond_t cond, input word_t a,
                                             input word_t b, input logic vi);
      logic res;
      case (cond)
         4'h0:       res = 1'b0;
         4'h1:       res = (a < b);
         4'h2:       res = (a == b);
         4'h3:       res = (a <= b);
         4'h4:       res = (a > b);
         4'h5:       res = (a != b);
         4'h6:       res = (a >= b);
         4'h7, 4'h8: res = vi;             // VCC passes through undefined codes
         4'h9:       res = !(a >= b);
         4'hA:       res = (a == b);
         4'hB:       res = !(a > b);
         4'hC:       res = !(a <= b);
         4'hD:       res = (a != b);
         4'hE:       res = !(a < b);
         default:    res = 1'b1;
      endcase
      return res;
   endfunction

   // Edge index counts posedges after the one that sampled start
   task automatic wait_done(input int base, output int edge_idx);
      logic seen;
      seen     = 1'b0;
      edge_idx = base;
      while (!seen && !timed_out)
      begin
         @(negedge clk);
         if (done)
            seen = 1'b1;
         else
         begin
            edge_idx++;
            if (edge_idx > DONE_TIMEOUT)
            begin
               timed_out = 1'b1;
               $display("Timeout: done did not arrive within %0d cycles", DONE_TIMEOUT);
            end
         end
      end
   endtask

   task automatic run_vector(input string name, input ctrl_t c, input word_t a, input word_t b,
                             input logic ex, input logic vi, input word_t exp_vgpr,
                             input logic exp_vcc);
      int edge_idx;
      int errs_before;
      errs_before = error_count;
      @(posedge clk);
      ctrl   <= c;
      src1   <= a;
      src2   <= b;
      exec_v <= ex;
      vcc_in <= vi;
      start  <= 1'b1;
      @(posedge clk);
      start <= 1'b0;                       // This edge samples the pulse
      wait_done(0, edge_idx);
      if (!timed_out)
      begin
         check_word("alu_vgpr_dest_data_o", exp_vgpr, vgpr_out);
         check_bit("alu_dest_vcc_value_o", exp_vcc, vcc_out);
         check_count("done edge", done_edge(c, ex), edge_idx);
         @(negedge clk);
         check_bit("alu_done_o", 1'b0, done);
      end
      report_test(name, errs_before);
   endtask

   task automatic check_idle_after_reset;
      int errs_before;
      int i;
      errs_before = error_count;
      for (i = 0; i < 4; i++)
      begin
         @(negedge clk);
         check_bit("alu_done_o", 1'b0, done);
      end
      check_word("alu_vgpr_dest_data_o", 32'h0, vgpr_out);
      check_bit("alu_dest_vcc_value_o", 1'b0, vcc_out);
      report_test("reset_idle", errs_before);
   endtask

   task automatic replay_trace;
      int              fd;
      int              n;
      int              vectors;
      string           line;
      logic [8*24-1:0] tag;
      ctrl_t           c;
      word_t           a;
      word_t           b;
      word_t           ev;
      logic            ex;
      logic            vi;
      logic            ev_cc;
      vectors = 0;
      fd = $fopen("testbench/simf_alu_trace.txt", "r");
      if (fd == 0)
      begin
         file_error = 1'b1;
         $display("Could not open the trace file testbench/simf_alu_trace.txt");
      end
      else
      begin
         while (!$feof(fd) && !timed_out)
         begin
            n = $fgets(line, fd);
            if ((n > 0) && (line.getc(0) != "#"))
            begin
               n = $sscanf(line, "%s %h %h %h %h %h %h %h", tag, c, a, b, ex, vi, ev, ev_cc);
               if (n == 8)
               begin
                  run_vector($sformatf("%0s", tag), c, a, b, ex, vi, ev, ev_cc);
                  vgpr_model = ev;
                  vectors++;
               end
            end
         end
         $fclose(fd);
         if (vectors == 0)
         begin
            file_error = 1'b1;
            $display("The trace file holds no usable vectors");
         end
      end
   endtask

   // Second start lands at edge 6 while the multiply is running
   task automatic busy_start_test;
      int edge_idx;
      int errs_before;
      int extra;
      int i;
      errs_before = error_count;
      extra       = 0;
      @(posedge clk);
      ctrl   <= {FMT_VOP2, 12'h000, OPC_MUL_VOP2};
      src1   <= 32'h4000_0000;
      src2   <= 32'h4040_0000;
      exec_v <= 1'b1;
      vcc_in <= 1'b1;
      start  <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      for (i = 1; i < 6; i++)
         @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      wait_done(6, edge_idx);
      if (!timed_out)
      begin
         check_word("alu_vgpr_dest_data_o", 32'h40c0_0000, vgpr_out);
         check_bit("alu_dest_vcc_value_o", 1'b1, vcc_out);
         check_count("done edge", 25, edge_idx);
         for (i = 0; i < 30; i++)
         begin
            @(negedge clk);
            if (done)
               extra++;
         end
         if (extra != 0)
         begin
            error_count++;
            $display("A start issued during a multiply produced a second done pulse");
         end
      end
      vgpr_model = 32'h40c0_0000;
      report_test("mul_busy_start", errs_before);
   endtask

   task automatic random_compares(input int count);
      word_t     r;
      word_t     a;
      word_t     b;
      cmp_cond_t cond;
      ctrl_t     c;
      logic      vi;
      int        k;
      for (k = 0; (k < count) && !timed_out; k++)
      begin
         r = $random(seed);
         a = $random(seed);
         if (r[7:6] == 2'b00)
            b = a;                         // Some equal pairs
         else
            b = $random(seed);
         cond = r[3:0];
         vi   = r[5];
         c    = {(r[4] ? FMT_VOP3A : FMT_VOPC), 12'h000, 8'h00, cond};
         run_vector($sformatf("rand_cmp_%0d_code_%0h", k, cond), c, a, b, 1'b1, vi,
                    vgpr_model, compare_expected(cond, a, b, vi));
      end
   endtask

   initial
   begin
      int i;
      seed         = 32'hb90f_4d3c;
      test_count   = 0;
      failed_tests = 0;
      check_total  = 0;
      error_count  = 0;
      timed_out    = 1'b0;
      file_error   = 1'b0;
      vgpr_model   = '0;
      rst_n        = 1'b0;
      src1         = '0;
      src2         = '0;
      ctrl         = '0;
      exec_v       = 1'b0;
      vcc_in       = 1'b0;
      start        = 1'b0;
      for (i = 0; i < 3; i++)
         @(posedge clk);
      rst_n <= 1'b1;
      check_idle_after_reset();
      replay_trace();
      if (!timed_out)
         busy_start_test();
      if (!timed_out)
         random_compares(RANDOM_CMPS);
      $display("Summary: %0d tests, %0d failed tests, %0d checks, %0d errors",
               test_count, failed_tests, check_total, error_count);
      if (timed_out || file_error || (error_count != 0))
         $display("Checks failed");
      else
         $display("All checks passed");
      $finish;
   end

endmodule

// ==== testbench/simf_alu_trace.txt ====
# tag ctrl src1 src2 exec vcc_in exp_vgpr exp_vcc, all values hex except the tag
# ctrl holds the format in bits 31:24 and the opcode in bits 11:0
mul_2x3        02000008 40000000 40400000 1 0 40c00000 0
mul_sq_1p5     08000108 3fc00000 3fc00000 1 1 40100000 1
mul_neg        02000008 c0200000 40800000 1 1 c1200000 1
mul_trunc_lo   08000108 3f800001 3f800001 1 0 3f800002 0
mul_trunc_hi   02000008 3fffffff 3fffffff 1 0 407ffffe 0
mul_zero_neg   02000008 80000000 40400000 1 0 80000000 0
mul_zero_exp   08000108 40400000 00400000 1 1 00000000 1
mul_uflow      02000008 80800000 3f000000 1 0 80000000 0
mul_max_norm   08000108 7f000000 3f800000 1 0 7f000000 0
mul_oflow      02000008 7f000000 40000000 1 1 7f800000 1
mul_oflow_neg  08000108 ff000000 40000000 1 0 ff800000 0
mul_oflow_norm 02000008 7f400000 3fc00000 1 0 7f800000 0
max_a          02000010 40400000 40000000 1 1 40400000 1
max_b          02000010 3f800000 bf800000 1 0 bf800000 0
max_tie        02000010 12345678 12345678 1 1 12345678 1
cmpc_f         04000000 00000010 00000020 1 1 12345678 0
cmpc_lt        04000001 00000010 00000020 1 0 12345678 1
cmpc_eq        04000002 00000010 00000020 1 1 12345678 0
cmpc_le        04000003 00000010 00000020 1 0 12345678 1
cmpc_gt        04000004 00000010 00000020 1 1 12345678 0
cmpc_lg        04000005 00000010 00000020 1 0 12345678 1
cmpc_ge        04000006 00000010 00000020 1 1 12345678 0
cmpc_nge       04000009 00000010 00000020 1 0 12345678 1
cmpc_nlg       0400000a 00000010 00000020 1 1 12345678 0
cmpc_ngt       0400000b 00000010 00000020 1 0 12345678 1
cmpc_nle       0400000c 00000010 00000020 1 1 12345678 0
cmpc_neq       0400000d 00000010 00000020 1 0 12345678 1
cmpc_nlt       0400000e 00000010 00000020 1 1 12345678 0
cmpc_tru       0400000f 00000010 00000020 1 0 12345678 1
cmp3_eq        08000002 80000000 80000000 1 0 12345678 1
cmp3_gt        08000004 80000000 7fffffff 1 0 12345678 1
cmp3_nle       0800000c 80000000 7fffffff 1 0 12345678 1
cmp3_nlt       0800000e 7fffffff 80000000 1 1 12345678 0
cmpc_code7     04000007 00000010 00000020 1 1 12345678 1
cmp3_code8     08000008 00000010 00000020 1 0 12345678 0
exec_off_mul   02000008 40000000 40400000 0 1 12345678 1
exec_off_cmp   04000001 00000010 00000020 0 0 12345678 0
unknown_vop2   02000033 40000000 40400000 1 1 12345678 1
unknown_vop1   01000008 40000000 40400000 1 0 12345678 0
unknown_vop3   08000010 40000000 40400000 1 0 12345678 0
unknown_fmt    10000008 40000000 40400000 1 1 12345678 1
